/* vlog.f */
logic/pcis_pkg.sv
logic/pcis_req_fifo.sv
logic/pcis_req_decode.sv
logic/pcis_wr_issue.sv
logic/pcis_rd_issue.sv
logic/pcis_resp_collect.sv
logic/sh_pcis_master.sv
dv/pcis_checker.sv
dv/tb_sh_pcis_master.sv

/* Bender.yml */
package:
  name: sh_pcis_master

sources:
  - logic/pcis_pkg.sv
  - logic/pcis_req_fifo.sv
  - logic/pcis_req_decode.sv
  - logic/pcis_wr_issue.sv
  - logic/pcis_rd_issue.sv
  - logic/pcis_resp_collect.sv
  - logic/sh_pcis_master.sv
  - target: simulation
    files:
      - dv/pcis_checker.sv
      - dv/tb_sh_pcis_master.sv

/* dv/tb_sh_pcis_master.sv */
`timescale 1ns/1ps

module tb_sh_pcis_master;
   import pcis_pkg::*;

   localparam int N_REQ     = 400;
   localparam int LIMIT     = N_REQ * 40;
   localparam int STALL_AT  = 200;
   localparam int STALL_LEN = 80;
   localparam logic [ADDR_W-1:0] BASE = 64'h0000_00a0_0000_0000;

   logic clk_out, rst_n_i;
   logic req_valid_i, req_write_i, req_full_o;
   logic [ADDR_W-1:0] req_addr_i, awaddr_o, araddr_o;
   logic [ID_W-1:0]   req_id_i, wr_id_o, rd_id_o, awid_o, bid_i, arid_o, rid_i;
   logic [WORD_W-1:0] req_wdata_i, rd_data_o;
   logic wr_done_o, rd_done_o;
   logic [RESP_W-1:0] wr_resp_o, rd_resp_o, bresp_i, rresp_i;
   logic awvalid_o, awready_i, wvalid_o, wready_i, wlast_o;
   logic [LEN_W-1:0]  awlen_o, arlen_o;
   logic [BUS_W-1:0]  wdata_o, rdata_i;
   logic [STRB_W-1:0] wstrb_o;
   logic bvalid_i, bready_o, arvalid_o, arready_i, rvalid_i, rready_o, rlast_i;

   int err_cnt, check_cnt, req_cnt, done_cnt, wr_pend, rd_pend;
   logic full_seen;
   int tb_err, cycle, stall_until, b_last_due, r_last_due;
   logic [31:0] stim_state, slave_state;

   // Slave memory and in-order response queues
   logic [BUS_W-1:0]  line_mem [16];
   logic [ADDR_W-1:0] aw_addr_q [$];
   logic [ID_W-1:0]   aw_id_q [$];
   logic [BUS_W-1:0]  w_data_q [$];
   logic [STRB_W-1:0] w_strb_q [$];
   logic [ID_W-1:0]   b_id_q [$];
   int                b_due_q [$];
   logic [ID_W-1:0]   r_id_q [$];
   logic [BUS_W-1:0]  r_data_q [$];
   int                r_due_q [$];
   logic [ADDR_W-1:0] wr_addr;
   logic [BUS_W-1:0]  wr_data;
   logic [STRB_W-1:0] wr_strb;
   logic              is_write;

   sh_pcis_master DUT (.*);

   pcis_checker u_checker (
      .clk_out(clk_out), .rst_n_i(rst_n_i),
      .req_valid_i(req_valid_i), .req_write_i(req_write_i), .req_addr_i(req_addr_i),
      .req_id_i(req_id_i), .req_wdata_i(req_wdata_i), .req_full_i(req_full_o),
      .awvalid_i(awvalid_o), .awready_i(awready_i), .awaddr_i(awaddr_o), .awlen_i(awlen_o),
      .wvalid_i(wvalid_o), .wready_i(wready_i), .wdata_i(wdata_o), .wstrb_i(wstrb_o),
      .wlast_i(wlast_o), .arvalid_i(arvalid_o), .arready_i(arready_i), .araddr_i(araddr_o),
      .arlen_i(arlen_o), .bready_i(bready_o), .rready_i(rready_o),
      .wr_done_i(wr_done_o), .wr_id_i(wr_id_o), .wr_resp_i(wr_resp_o),
      .rd_done_i(rd_done_o), .rd_id_i(rd_id_o), .rd_resp_i(rd_resp_o), .rd_data_i(rd_data_o),
      .err_cnt_o(err_cnt), .check_cnt_o(check_cnt), .req_cnt_o(req_cnt),
      .done_cnt_o(done_cnt), .wr_pend_o(wr_pend), .rd_pend_o(rd_pend),
      .full_seen_o(full_seen)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   task automatic report_counts();
      $display("checks=%0d errors=%0d requests=%0d completions=%0d",
               check_cnt, err_cnt + tb_err, req_cnt, done_cnt);
   endtask

   initial begin
      clk_out = 1'b0;
      forever #10 clk_out = ~clk_out;
   end

   // Cycle count and timeout
   always @(posedge clk_out) begin
      cycle = cycle + 1;
      if (cycle >= LIMIT) begin
         tb_err++;
         $display("Timeout: run did not finish within %0d cycles", LIMIT);
         report_counts();
         $display("Test FAILED");
         $finish;
      end
   end

   // -------------------------------------------------------------------------
   // Stimulus
   // -------------------------------------------------------------------------
   initial begin
      {rst_n_i, req_valid_i, req_write_i, req_addr_i, req_id_i, req_wdata_i} = '0;
      {awready_i, wready_i, arready_i, bvalid_i, bid_i, bresp_i} = '0;
      {rvalid_i, rid_i, rdata_i, rresp_i, rlast_i} = '0;
      {tb_err, cycle, stall_until, b_last_due, r_last_due} = '0;
      stim_state  = 32'd74;
      slave_state = 32'd74 ^ 32'h9e37_79b9;
      is_write    = 1'b1;
      for (int i = 0; i < 16; i++) begin
         line_mem[i] = '0;
      end
      repeat (8) @(posedge clk_out);
      #1 rst_n_i = 1'b1;
      for (int n = 0; n < N_REQ; n++) begin
         stim_state = xorshift(stim_state);
         repeat (stim_state % 4) @(posedge clk_out);
         #1;
         // Kind runs fixed across the stall so a queue fills up
         stim_state = xorshift(stim_state);
         if ((stim_state % 4 == 0) && (n < STALL_AT || n > STALL_AT + 16)) begin
            is_write = !is_write;
         end
         if (n == STALL_AT) begin
            stall_until = cycle + STALL_LEN;
         end
         // Other kind drains first so each peek sees a settled model
         while (req_full_o || (is_write ? rd_pend != 0 : wr_pend != 0)) begin
            @(posedge clk_out);
            #1;
         end
         stim_state  = xorshift(stim_state);
         req_valid_i = 1'b1;
         req_write_i = is_write;
         req_id_i    = stim_state[4:0];
         req_addr_i  = BASE + (stim_state[8:5] * 64) + (stim_state[12:9] * 4);
         stim_state  = xorshift(stim_state);
         req_wdata_i = stim_state;
         @(posedge clk_out);
         #1 req_valid_i = 1'b0;
      end
      while (done_cnt < N_REQ) begin
         @(posedge clk_out);
      end
      repeat (5) @(posedge clk_out);
      if (!full_seen) begin
         tb_err++;
         $display("req_full_o never rose during the back-pressure stretch");
      end
      if (done_cnt != req_cnt) begin
         tb_err++;
         $display("Completion count differs from request count");
      end
      report_counts();
      if (err_cnt + tb_err == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // -------------------------------------------------------------------------
   // AXI slave model
   // -------------------------------------------------------------------------
   always @(posedge clk_out) begin
      if (awvalid_o && awready_i) begin
         aw_addr_q.push_back(awaddr_o);
         aw_id_q.push_back(awid_o);
      end
      if (wvalid_o && wready_i) begin
         w_data_q.push_back(wdata_o);
         w_strb_q.push_back(wstrb_o);
      end
      if (arvalid_o && arready_i) begin
         r_id_q.push_back(arid_o);
         r_data_q.push_back(line_mem[araddr_o[9:6]]);
      end
      if (bvalid_i && bready_o) begin
         void'(b_id_q.pop_front());
         void'(b_due_q.pop_front());
      end
      if (rvalid_i && rready_o) begin
         void'(r_id_q.pop_front());
         void'(r_data_q.pop_front());
         void'(r_due_q.pop_front());
      end
      #1;
      // Read accepted on this edge gets its due cycle
      if (r_due_q.size() < r_id_q.size()) begin
         slave_state = xorshift(slave_state);
         r_last_due  = (cycle + slave_state % 6 > r_last_due) ? cycle + slave_state % 6
                                                              : r_last_due;
         r_due_q.push_back(r_last_due);
      end
      // Write lands once both its address and data have arrived
      while (aw_addr_q.size() > 0 && w_data_q.size() > 0) begin
         wr_addr = aw_addr_q.pop_front();
         wr_data = w_data_q.pop_front();
         wr_strb = w_strb_q.pop_front();
         for (int i = 0; i < STRB_W; i++) begin
            if (wr_strb[i]) begin
               line_mem[wr_addr[9:6]][i*8 +: 8] = wr_data[i*8 +: 8];
            end
         end
         b_id_q.push_back(aw_id_q.pop_front());
         slave_state = xorshift(slave_state);
         b_last_due  = (cycle + slave_state % 6 > b_last_due) ? cycle + slave_state % 6
                                                              : b_last_due;
         b_due_q.push_back(b_last_due);
      end
      bvalid_i = (b_due_q.size() > 0) && (b_due_q[0] <= cycle);
      bid_i    = bvalid_i ? b_id_q[0] : '0;
      bresp_i  = RESP_OKAY;
      rvalid_i = (r_due_q.size() > 0) && (r_due_q[0] <= cycle);
      rid_i    = rvalid_i ? r_id_q[0] : '0;
      rdata_i  = rvalid_i ? r_data_q[0] : '0;
      rresp_i  = RESP_OKAY;
      rlast_i  = 1'b1;
      slave_state = xorshift(slave_state);
      awready_i = (cycle >= stall_until) && (slave_state[1:0] != 2'b00);
      wready_i  = (cycle >= stall_until) && (slave_state[3:2] != 2'b00);
      arready_i = (cycle >= stall_until) && (slave_state[5:4] != 2'b00);
   end

endmodule

/* dv/pcis_checker.sv */
`timescale 1ns/1ps

module pcis_checker (
   input  logic                        clk_out,
   input  logic                        rst_n_i,
   input  logic                        req_valid_i,
   input  logic                        req_write_i,
   input  logic [pcis_pkg::ADDR_W-1:0] req_addr_i,
   input  logic [pcis_pkg::ID_W-1:0]   req_id_i,
   input  logic [pcis_pkg::WORD_W-1:0] req_wdata_i,
   input  logic                        req_full_i,
   input  logic                        awvalid_i,
   input  logic                        awready_i,
   input  logic [pcis_pkg::ADDR_W-1:0] awaddr_i,
   input  logic [pcis_pkg::LEN_W-1:0]  awlen_i,
   input  logic                        wvalid_i,
   input  logic                        wready_i,
   input  logic [pcis_pkg::BUS_W-1:0]  wdata_i,
   input  logic [pcis_pkg::STRB_W-1:0] wstrb_i,
   input  logic                        wlast_i,
   input  logic                        arvalid_i,
   input  logic                        arready_i,
   input  logic [pcis_pkg::ADDR_W-1:0] araddr_i,
   input  logic [pcis_pkg::LEN_W-1:0]  arlen_i,
   input  logic                        bready_i,
   input  logic                        rready_i,
   input  logic                        wr_done_i,
   input  logic [pcis_pkg::ID_W-1:0]   wr_id_i,
   input  logic [pcis_pkg::RESP_W-1:0] wr_resp_i,
   input  logic                        rd_done_i,
   input  logic [pcis_pkg::ID_W-1:0]   rd_id_i,
   input  logic [pcis_pkg::RESP_W-1:0] rd_resp_i,
   input  logic [pcis_pkg::WORD_W-1:0] rd_data_i,
   output int                          err_cnt_o,
   output int                          check_cnt_o,
   output int                          req_cnt_o,
   output int                          done_cnt_o,
   output int                          wr_pend_o,
   output int                          rd_pend_o,
   output logic                        full_seen_o
);
   import pcis_pkg::*;

   // Word model over the 16-line window, addressed by bits 9:2
   logic [WORD_W-1:0] model [256];
   logic [ADDR_W-1:0] poke_addr_q [$];
   logic [WORD_W-1:0] poke_data_q [$];
   logic [ID_W-1:0]   wr_id_q [$];
   logic [ID_W-1:0]   rd_id_q [$];
   logic [WORD_W-1:0] rd_exp_q [$];
   logic              seen_req;
   logic              aw_wait;
   logic              w_wait;
   logic              ar_wait;
   logic [ADDR_W-1:0] prev_awaddr;
   logic [ADDR_W-1:0] prev_araddr;
   logic [BUS_W-1:0]  prev_wdata;
   logic [STRB_W-1:0] prev_wstrb;
   lane_t             lane;

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
      check_cnt_o++;
      if (exp !== act) begin
         err_cnt_o++;
         $display("Fail %s: expected %0h actual %0h", name, exp, act);
      end
   endtask

   initial begin
      err_cnt_o   = 0;
      check_cnt_o = 0;
      req_cnt_o   = 0;
      done_cnt_o  = 0;
      wr_pend_o   = 0;
      rd_pend_o   = 0;
      full_seen_o = 1'b0;
      seen_req    = 1'b0;
      aw_wait     = 1'b0;
      w_wait      = 1'b0;
      ar_wait     = 1'b0;
      for (int i = 0; i < 256; i++) begin
         model[i] = '0;
      end
   end

   always @(posedge clk_out) begin
      if (rst_n_i) begin
         if (req_valid_i) begin
            seen_req = 1'b1;
         end
         // Quiet bus from reset release up to the first request
         if (!seen_req) begin
            compare("reset_valids", 0, {awvalid_i, wvalid_i, arvalid_i});
            compare("reset_dones", 0, {wr_done_i, rd_done_i});
            compare("reset_readies", 3, {bready_i, rready_i});
         end
         if (req_full_i) begin
            full_seen_o = 1'b1;
         end

         // ------------------------------------------------------------------
         // Valids hold with stable payload until their handshake
         // ------------------------------------------------------------------
         if (aw_wait) begin
            compare("aw_hold_valid", 1, awvalid_i);
            compare("aw_hold_addr", prev_awaddr, awaddr_i);
         end
         if (w_wait) begin
            compare("w_hold_valid", 1, wvalid_i);
            compare("w_hold_strb", prev_wstrb, wstrb_i);
            compare("w_hold_data", 1, wdata_i == prev_wdata);
         end
         if (ar_wait) begin
            compare("ar_hold_valid", 1, arvalid_i);
            compare("ar_hold_addr", prev_araddr, araddr_i);
         end
         aw_wait     = awvalid_i && !awready_i;
         w_wait      = wvalid_i && !wready_i;
         ar_wait     = arvalid_i && !arready_i;
         prev_awaddr = awaddr_i;
         prev_araddr = araddr_i;
         prev_wdata  = wdata_i;
         prev_wstrb  = wstrb_i;

         // Single-beat reads
         if (arvalid_i && arready_i) begin
            compare("ar_len", 0, arlen_i);
         end

         // Lane placement, checked against the oldest unsent poke
         if (wvalid_i && wready_i) begin
            if (poke_addr_q.size() == 0) begin
               err_cnt_o++;
               $display("W handshake seen with no poke waiting");
            end else begin
               lane = {poke_addr_q[0][5:2], 2'b00};
               compare("w_addr", poke_addr_q[0], awaddr_i);
               compare("w_strb", 64'hf << lane, wstrb_i);
               compare("w_word", poke_data_q[0], wdata_i[lane*8 +: 32]);
               compare("w_len_last", 1, {awlen_i, wlast_i});
               void'(poke_addr_q.pop_front());
               void'(poke_data_q.pop_front());
            end
         end

         if (req_valid_i) begin
            req_cnt_o++;
            if (req_write_i) begin
               model[req_addr_i[9:2]] = req_wdata_i;
               poke_addr_q.push_back(req_addr_i);
               poke_data_q.push_back(req_wdata_i);
               wr_id_q.push_back(req_id_i);
               wr_pend_o++;
            end else begin
               rd_id_q.push_back(req_id_i);
               rd_exp_q.push_back(model[req_addr_i[9:2]]);
               rd_pend_o++;
            end
         end

         if (wr_done_i) begin
            done_cnt_o++;
            if (wr_id_q.size() == 0) begin
               err_cnt_o++;
               $display("Write completion with no poke outstanding");
            end else begin
               compare("wr_id", wr_id_q.pop_front(), wr_id_i);
               compare("wr_resp", RESP_OKAY, wr_resp_i);
               wr_pend_o--;
            end
         end
         if (rd_done_i) begin
            done_cnt_o++;
            if (rd_id_q.size() == 0) begin
               err_cnt_o++;
               $display("Read completion with no peek outstanding");
            end else begin
               compare("rd_id", rd_id_q.pop_front(), rd_id_i);
               compare("rd_data", rd_exp_q.pop_front(), rd_data_i);
               compare("rd_resp", RESP_OKAY, rd_resp_i);
               rd_pend_o--;
            end
         end
      end
   end

endmodule

/* logic/sh_pcis_master.sv */
`timescale 1ns/1ps

module sh_pcis_master (
   input  logic                        clk_out,
   input  logic                        rst_n_i,

   input  logic                        req_valid_i,
   input  logic                        req_write_i,
   input  logic [pcis_pkg::ADDR_W-1:0] req_addr_i,
   input  logic [pcis_pkg::ID_W-1:0]   req_id_i,
   input  logic [pcis_pkg::WORD_W-1:0] req_wdata_i,
   output logic                        req_full_o,

   output logic                        wr_done_o,
   output logic [pcis_pkg::ID_W-1:0]   wr_id_o,
   output logic [pcis_pkg::RESP_W-1:0] wr_resp_o,
   output logic                        rd_done_o,
   output logic [pcis_pkg::ID_W-1:0]   rd_id_o,
   output logic [pcis_pkg::RESP_W-1:0] rd_resp_o,
   output logic [pcis_pkg::WORD_W-1:0] rd_data_o,

   // ------------------------------------------------------------------------
   // AXI-4 master port
   // ------------------------------------------------------------------------
   output logic                        awvalid_o,
   input  logic                        awready_i,
   output logic [pcis_pkg::ADDR_W-1:0] awaddr_o,
   output logic [pcis_pkg::ID_W-1:0]   awid_o,
   output logic [pcis_pkg::LEN_W-1:0]  awlen_o,

   output logic                        wvalid_o,
   input  logic                        wready_i,
   output logic [pcis_pkg::BUS_W-1:0]  wdata_o,
   output logic [pcis_pkg::STRB_W-1:0] wstrb_o,
   output logic                        wlast_o,

   input  logic                        bvalid_i,
   output logic                        bready_o,
   input  logic [pcis_pkg::ID_W-1:0]   bid_i,
   input  logic [pcis_pkg::RESP_W-1:0] bresp_i,

   output logic                        arvalid_o,
   input  logic                        arready_i,
   output logic [pcis_pkg::ADDR_W-1:0] araddr_o,
   output logic [pcis_pkg::ID_W-1:0]   arid_o,
   output logic [pcis_pkg::LEN_W-1:0]  arlen_o,

   input  logic                        rvalid_i,
   output logic                        rready_o,
   input  logic [pcis_pkg::ID_W-1:0]   rid_i,
   input  logic [pcis_pkg::BUS_W-1:0]  rdata_i,
   input  logic [pcis_pkg::RESP_W-1:0] rresp_i,
   input  logic                        rlast_i
);
   import pcis_pkg::*;

   wr_req_t wr_req;
   wr_req_t wr_head;
   rd_req_t rd_req;
   rd_req_t rd_head;
   lane_t   rd_lane;
   logic    wr_push;
   logic    wr_pop;
   logic    wr_empty;
   logic    wr_full;
   logic    rd_push;
   logic    rd_pop;
   logic    rd_empty;
   logic    rd_full;
   logic    wr_idle;
   logic    rd_idle;
   logic    b_fire;
   logic    r_fire;

   // Requester holds off while either queue is out of room
   assign req_full_o = wr_full || rd_full;

   pcis_req_decode u_decode (
      .clk_out     (clk_out),
      .rst_n_i     (rst_n_i),
      .req_valid_i (req_valid_i),
      .req_write_i (req_write_i),
      .req_addr_i  (req_addr_i),
      .req_id_i    (req_id_i),
      .req_wdata_i (req_wdata_i),
      .wr_full_i   (wr_full),
      .rd_full_i   (rd_full),
      .wr_push_o   (wr_push),
      .wr_req_o    (wr_req),
      .rd_push_o   (rd_push),
      .rd_req_o    (rd_req)
   );

   pcis_req_fifo #(
      .payload_t (wr_req_t)
   ) u_wr_q (
      .clk_out     (clk_out),
      .rst_n_i     (rst_n_i),
      .push_i      (wr_push),
      .push_data_i (wr_req),
      .pop_i       (wr_pop),
      .head_o      (wr_head),
      .empty_o     (wr_empty),
      .full_o      (wr_full)
   );

   pcis_req_fifo #(
      .payload_t (rd_req_t)
   ) u_rd_q (
      .clk_out     (clk_out),
      .rst_n_i     (rst_n_i),
      .push_i      (rd_push),
      .push_data_i (rd_req),
      .pop_i       (rd_pop),
      .head_o      (rd_head),
      .empty_o     (rd_empty),
      .full_o      (rd_full)
   );

   pcis_wr_issue u_wr_issue (
      .clk_out   (clk_out),
      .rst_n_i   (rst_n_i),
      .head_i    (wr_head),
      .empty_i   (wr_empty),
      .pop_o     (wr_pop),
      .rd_idle_i (rd_idle),
      .b_fire_i  (b_fire),
      .wr_idle_o (wr_idle),
      .awvalid_o (awvalid_o),
      .awready_i (awready_i),
      .awaddr_o  (awaddr_o),
      .awid_o    (awid_o),
      .awlen_o   (awlen_o),
      .wvalid_o  (wvalid_o),
      .wready_i  (wready_i),
      .wdata_o   (wdata_o),
      .wstrb_o   (wstrb_o),
      .wlast_o   (wlast_o)
   );

   pcis_rd_issue u_rd_issue (
      .clk_out   (clk_out),
      .rst_n_i   (rst_n_i),
      .head_i    (rd_head),
      .empty_i   (rd_empty),
      .pop_o     (rd_pop),
      .wr_idle_i (wr_idle),
      .r_fire_i  (r_fire),
      .rd_idle_o (rd_idle),
      .arvalid_o (arvalid_o),
      .arready_i (arready_i),
      .araddr_o  (araddr_o),
      .arid_o    (arid_o),
      .arlen_o   (arlen_o),
      .lane_o    (rd_lane)
   );

   pcis_resp_collect u_resp (
      .clk_out   (clk_out),
      .rst_n_i   (rst_n_i),
      .bvalid_i  (bvalid_i),
      .bready_o  (bready_o),
      .bid_i     (bid_i),
      .bresp_i   (bresp_i),
      .rvalid_i  (rvalid_i),
      .rready_o  (rready_o),
      .rid_i     (rid_i),
      .rdata_i   (rdata_i),
      .rresp_i   (rresp_i),
      .rlast_i   (rlast_i),
      .lane_i    (rd_lane),
      .b_fire_o  (b_fire),
      .r_fire_o  (r_fire),
      .wr_done_o (wr_done_o),
      .wr_id_o   (wr_id_o),
      .wr_resp_o (wr_resp_o),
      .rd_done_o (rd_done_o),
      .rd_id_o   (rd_id_o),
      .rd_resp_o (rd_resp_o),
      .rd_data_o (rd_data_o)
   );

endmodule

/* logic/pcis_resp_collect.sv */
`timescale 1ns/1ps

module pcis_resp_collect (
   input  logic                        clk_out,
   input  logic                        rst_n_i,

   input  logic                        bvalid_i,
   output logic                        bready_o,
   input  logic [pcis_pkg::ID_W-1:0]   bid_i,
   input  logic [pcis_pkg::RESP_W-1:0] bresp_i,

   input  logic                        rvalid_i,
   output logic                        rready_o,
   input  logic [pcis_pkg::ID_W-1:0]   rid_i,
   input  logic [pcis_pkg::BUS_W-1:0]  rdata_i,
   input  logic [pcis_pkg::RESP_W-1:0] rresp_i,
   input  logic                        rlast_i,

   input  pcis_pkg::lane_t             lane_i,

   output logic                        b_fire_o,
   output logic                        r_fire_o,

   output logic                        wr_done_o,
   output logic [pcis_pkg::ID_W-1:0]   wr_id_o,
   output logic [pcis_pkg::RESP_W-1:0] wr_resp_o,

   output logic                        rd_done_o,
   output logic [pcis_pkg::ID_W-1:0]   rd_id_o,
   output logic [pcis_pkg::RESP_W-1:0] rd_resp_o,
   output logic [pcis_pkg::WORD_W-1:0] rd_data_o
);
   import pcis_pkg::*;

   logic [WORD_W-1:0] r_word;

   // Completions are never back-pressured
   assign bready_o = 1'b1;
   assign rready_o = 1'b1;

   assign b_fire_o = bvalid_i && bready_o;
   assign r_fire_o = rvalid_i && rready_o;

   // Word of the oldest outstanding read
   assign r_word = rdata_i[{lane_i, 3'b000} +: WORD_W];

   always_ff @(posedge clk_out) begin
      if (!rst_n_i) begin
         wr_done_o <= 1'b0;
         rd_done_o <= 1'b0;
      end else begin
         wr_done_o <= b_fire_o;
         rd_done_o <= r_fire_o;
      end
   end

   always_ff @(posedge clk_out) begin
      if (b_fire_o) begin
         wr_id_o   <= bid_i;
         wr_resp_o <= bresp_i;
      end
      if (r_fire_o) begin
         rd_id_o   <= rid_i;
         rd_resp_o <= rresp_i;
         rd_data_o <= r_word;
      end
   end

   // Every read is a single beat
   a_rlast: assert property (@(posedge clk_out) disable iff (!rst_n_i)
      rvalid_i |-> rlast_i);

endmodule

/* logic/pcis_rd_issue.sv */
`timescale 1ns/1ps

module pcis_rd_issue (
   input  logic                        clk_out,
   input  logic                        rst_n_i,

   input  pcis_pkg::rd_req_t           head_i,
   input  logic                        empty_i,
   output logic                        pop_o,

   input  logic                        wr_idle_i,
   input  logic                        r_fire_i,
   output logic                        rd_idle_o,

   output logic                        arvalid_o,
   input  logic                        arready_i,
   output logic [pcis_pkg::ADDR_W-1:0] araddr_o,
   output logic [pcis_pkg::ID_W-1:0]   arid_o,
   output logic [pcis_pkg::LEN_W-1:0]  arlen_o,

   output pcis_pkg::lane_t             lane_o
);
   import pcis_pkg::*;

   logic             launch;
   logic             lane_full;
   lane_t            head_lane;
   logic [CNT_W-1:0] rd_cnt;

   assign head_lane = addr_lane(head_i.addr);

   assign araddr_o = head_i.addr;
   assign arid_o   = head_i.id;
   assign arlen_o  = '0;

   // Lane queue full means Q_DEPTH reads are already out
   assign launch = !arvalid_o && !empty_i && wr_idle_i && !lane_full;
   assign pop_o  = arvalid_o && arready_i;

   // A read launching now counts as busy, so a write cannot start alongside it
   assign rd_idle_o = !arvalid_o && (rd_cnt == '0) && !launch;

   always_ff @(posedge clk_out) begin
      if (!rst_n_i) begin
         arvalid_o <= 1'b0;
      end else if (launch) begin
         arvalid_o <= 1'b1;
      end else if (pop_o) begin
         arvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_out) begin
      if (!rst_n_i) begin
         rd_cnt <= '0;
      end else begin
         case ({pop_o, r_fire_i})
            2'b10:   rd_cnt <= rd_cnt + 1'b1;
            2'b01:   rd_cnt <= rd_cnt - 1'b1;
            default: rd_cnt <= rd_cnt;
         endcase
      end
   end

   // Lane of each accepted read, oldest at the head
   pcis_req_fifo #(
      .payload_t (lane_t)
   ) u_lane_q (
      .clk_out     (clk_out),
      .rst_n_i     (rst_n_i),
      .push_i      (pop_o),
      .push_data_i (head_lane),
      .pop_i       (r_fire_i),
      .head_o      (lane_o),
      .empty_o     (),
      .full_o      (lane_full)
   );

endmodule

/* logic/pcis_wr_issue.sv */
`timescale 1ns/1ps

module pcis_wr_issue (
   input  logic                        clk_out,
   input  logic                        rst_n_i,

   input  pcis_pkg::wr_req_t           head_i,
   input  logic                        empty_i,
   output logic                        pop_o,

   input  logic                        rd_idle_i,
   input  logic                        b_fire_i,
   output logic                        wr_idle_o,

   output logic                        awvalid_o,
   input  logic                        awready_i,
   output logic [pcis_pkg::ADDR_W-1:0] awaddr_o,
   output logic [pcis_pkg::ID_W-1:0]   awid_o,
   output logic [pcis_pkg::LEN_W-1:0]  awlen_o,

   output logic                        wvalid_o,
   input  logic                        wready_i,
   output logic [pcis_pkg::BUS_W-1:0]  wdata_o,
   output logic [pcis_pkg::STRB_W-1:0] wstrb_o,
   output logic                        wlast_o
);
   import pcis_pkg::*;

   logic             active;
   logic             launch;
   logic [CNT_W-1:0] wr_cnt;

   // Head stays put until popped, so AW and W payloads come straight from it
   assign awaddr_o = head_i.addr;
   assign awid_o   = head_i.id;
   assign awlen_o  = '0;
   assign wdata_o  = head_i.data;
   assign wstrb_o  = head_i.strb;
   assign wlast_o  = 1'b1;

   assign launch = !active && !empty_i && rd_idle_i && (wr_cnt < CNT_W'(Q_DEPTH));

   // Pop on the edge where the later of the two handshakes completes
   assign pop_o = active && (!awvalid_o || awready_i) && (!wvalid_o || wready_i);

   assign wr_idle_o = !active && (wr_cnt == '0);

   always_ff @(posedge clk_out) begin
      if (!rst_n_i) begin
         active    <= 1'b0;
         awvalid_o <= 1'b0;
         wvalid_o  <= 1'b0;
      end else if (launch) begin
         active    <= 1'b1;
         awvalid_o <= 1'b1;
         wvalid_o  <= 1'b1;
      end else begin
         if (pop_o) begin
            active <= 1'b0;
         end
         if (awvalid_o && awready_i) begin
            awvalid_o <= 1'b0;
         end
         if (wvalid_o && wready_i) begin
            wvalid_o <= 1'b0;
         end
      end
   end

   // Outstanding writes, issued but no B yet
   always_ff @(posedge clk_out) begin
      if (!rst_n_i) begin
         wr_cnt <= '0;
      end else begin
         case ({pop_o, b_fire_i})
            2'b10:   wr_cnt <= wr_cnt + 1'b1;
            2'b01:   wr_cnt <= wr_cnt - 1'b1;
            default: wr_cnt <= wr_cnt;
         endcase
      end
   end

   a_aw_stable: assert property (@(posedge clk_out) disable iff (!rst_n_i)
      (awvalid_o && !awready_i) |=> (awvalid_o && $stable(awaddr_o) && $stable(awid_o)));

endmodule

/* logic/pcis_req_decode.sv */
`timescale 1ns/1ps

module pcis_req_decode (
   input  logic                        clk_out,
   input  logic                        rst_n_i,

   input  logic                        req_valid_i,
   input  logic                        req_write_i,
   input  logic [pcis_pkg::ADDR_W-1:0] req_addr_i,
   input  logic [pcis_pkg::ID_W-1:0]   req_id_i,
   input  logic [pcis_pkg::WORD_W-1:0] req_wdata_i,

   input  logic                        wr_full_i,
   input  logic                        rd_full_i,

   output logic                        wr_push_o,
   output pcis_pkg::wr_req_t           wr_req_o,
   output logic                        rd_push_o,
   output pcis_pkg::rd_req_t           rd_req_o
);
   import pcis_pkg::*;

   lane_t req_lane;

   assign req_lane = addr_lane(req_addr_i);

   // -------------------------------------------------------------------------
   // Push strobes, one cycle behind the request
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_out) begin
      if (!rst_n_i) begin
         wr_push_o <= 1'b0;
         rd_push_o <= 1'b0;
      end else begin
         wr_push_o <= req_valid_i && req_write_i;
         rd_push_o <= req_valid_i && !req_write_i;
      end
   end

   // -------------------------------------------------------------------------
   // Payloads
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_out) begin
      if (req_valid_i && req_write_i) begin
         wr_req_o.addr <= req_addr_i;
         wr_req_o.id   <= req_id_i;
         // Word goes to byte offset lane, four strobe bits there
         wr_req_o.data <= BUS_W'(req_wdata_i) << {req_lane, 3'b000};
         wr_req_o.strb <= STRB_W'(4'hf) << req_lane;
      end
   end

   always_ff @(posedge clk_out) begin
      if (req_valid_i && !req_write_i) begin
         rd_req_o.addr <= req_addr_i;
         rd_req_o.id   <= req_id_i;
      end
   end

   // Requester has to honour the full level of the target queue
   a_req_not_full: assert property (@(posedge clk_out) disable iff (!rst_n_i)
      req_valid_i |-> !(req_write_i ? wr_full_i : rd_full_i));

endmodule

/* logic/pcis_req_fifo.sv */
`timescale 1ns/1ps

module pcis_req_fifo #(
   parameter type payload_t = logic
) (
   input  logic     clk_out,
   input  logic     rst_n_i,
   input  logic     push_i,
   input  payload_t push_data_i,
   input  logic     pop_i,
   output payload_t head_o,
   output logic     empty_o,
   output logic     full_o
);
   import pcis_pkg::*;

   payload_t         mem [Q_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   always_ff @(posedge clk_out) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= (wr_ptr == PTR_W'(Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= (rd_ptr == PTR_W'(Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_out) begin
      if (push_i) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   assign head_o  = mem[rd_ptr];
   assign empty_o = (count == '0);
   // An entry landing this cycle already takes the last slot
   assign full_o  = (count == CNT_W'(Q_DEPTH)) ||
                    ((count == CNT_W'(Q_DEPTH - 1)) && push_i && !pop_i);

   a_no_overflow: assert property (@(posedge clk_out) disable iff (!rst_n_i)
      push_i |-> (count != CNT_W'(Q_DEPTH)));

   a_no_underflow: assert property (@(posedge clk_out) disable iff (!rst_n_i)
      pop_i |-> !empty_o);

endmodule

/* logic/pcis_pkg.sv */
package pcis_pkg;

   // -------------------------------------------------------------------------
   // Bus and request widths
   // -------------------------------------------------------------------------
   localparam int ADDR_W = 64;
   localparam int ID_W   = 5;
   localparam int WORD_W = 32;
   localparam int BUS_W  = 512;
   localparam int STRB_W = BUS_W / 8;
   localparam int LANE_W = 6;
   localparam int RESP_W = 2;
   localparam int LEN_W  = 8;

   localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

   // Queue depth, also the limit on outstanding transfers of one kind
   localparam int Q_DEPTH = 4;
   localparam int PTR_W   = $clog2(Q_DEPTH);
   localparam int CNT_W   = $clog2(Q_DEPTH + 1);

   // Byte offset of a word inside a 64-byte beat
   typedef logic [LANE_W-1:0] lane_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [ID_W-1:0]   id;
      logic [BUS_W-1:0]  data;
      logic [STRB_W-1:0] strb;
   } wr_req_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [ID_W-1:0]   id;
   } rd_req_t;

   // Word-aligned lane from the low address bits
   function automatic lane_t addr_lane(input logic [ADDR_W-1:0] addr);
      return {addr[LANE_W-1:2], 2'b00};
   endfunction

endpackage
